//--- Makefile
# Verilator build and run for the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  := Test completed successfully

SRCS := $(wildcard logic/*.sv verif/*.sv)
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(EXE)
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/access_ctrl.sv
`timescale 1ns/100ps

// Load/store control: store lane decode, load tracking and extraction,
// and the merged register write port
module access_ctrl (
   input  logic                       clk,
   input  logic                       rst,
   input  lsu_pkg::mem_req_t          mem_req,
   input  lsu_pkg::rf_wr_t            ext_wr,
   input  lsu_pkg::reg_idx_t          rd_idx_b,
   input  lsu_pkg::word_t             store_data,
   input  lsu_pkg::word_t             ram_rdata,
   output lsu_pkg::reg_idx_t          store_idx,
   output logic [lsu_pkg::RAM_AW-1:0] ram_addr,
   output lsu_pkg::lane_mask_t        lane_mask,
   output lsu_pkg::word_t             ram_wdata,
   output lsu_pkg::rf_wr_t            rf_wr,
   output logic                       load_done
);

   logic                  is_store;
   logic                  is_load;
   lsu_pkg::lane_mask_t   size_mask;

   // Load in flight, written back in the cycle after the request
   logic                  ld_valid;
   lsu_pkg::access_size_e ld_size;
   logic [1:0]            ld_offset;
   lsu_pkg::reg_idx_t     ld_dest;

   logic [1:0]            eff_offset;
   lsu_pkg::word_t        shifted;
   lsu_pkg::word_t        load_data;

   assign is_store = mem_req.valid && mem_req.is_store;
   assign is_load  = mem_req.valid && !mem_req.is_store;

   // Port 2 is borrowed for the store source in a store cycle
   assign store_idx = is_store ? mem_req.reg_idx : rd_idx_b;
   assign ram_addr  = mem_req.addr[lsu_pkg::BYTE_AW-1:2];

   // Store lanes and replicated data
   always_comb begin
      case (mem_req.size)
         lsu_pkg::SIZE_BYTE: begin
            size_mask = 4'b0001 << mem_req.addr[1:0];
            ram_wdata = {4{store_data[7:0]}};
         end
         lsu_pkg::SIZE_HALF: begin
            size_mask = 4'b0011 << {mem_req.addr[1], 1'b0};   // Bit 0 ignored
            ram_wdata = {2{store_data[15:0]}};
         end
         default: begin
            size_mask = 4'b1111;
            ram_wdata = store_data;
         end
      endcase
   end

   assign lane_mask = is_store ? size_mask : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         ld_valid <= 1'b0;
      end else begin
         ld_valid <= is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (is_load) begin
         ld_size   <= mem_req.size;
         ld_offset <= mem_req.addr[1:0];
         ld_dest   <= mem_req.reg_idx;
      end
   end

   // Align to lane 0, then zero-extend
   always_comb begin
      case (ld_size)
         lsu_pkg::SIZE_BYTE: eff_offset = ld_offset;
         lsu_pkg::SIZE_HALF: eff_offset = {ld_offset[1], 1'b0};
         default:            eff_offset = 2'b00;
      endcase
      shifted = ram_rdata >> {eff_offset, 3'b000};
      case (ld_size)
         lsu_pkg::SIZE_BYTE: load_data = {24'b0, shifted[7:0]};
         lsu_pkg::SIZE_HALF: load_data = {16'b0, shifted[15:0]};
         default:            load_data = shifted;
      endcase
   end

   // Load write-back wins over the external write
   always_comb begin
      if (ld_valid) begin
         rf_wr.valid = 1'b1;
         rf_wr.idx   = ld_dest;
         rf_wr.data  = load_data;
      end else begin
         rf_wr = ext_wr;
      end
   end

   assign load_done = ld_valid;

endmodule

//--- logic/data_ram.sv
`timescale 1ns/100ps

// Single-port word RAM with a registered read and per-byte write enables
module data_ram (
   input  logic                       clk,
   input  logic [lsu_pkg::RAM_AW-1:0] word_addr,
   input  lsu_pkg::lane_mask_t        lane_mask,
   input  lsu_pkg::word_t             wdata,
   output lsu_pkg::word_t             rdata
);

   lsu_pkg::word_t mem [lsu_pkg::RAM_DEPTH];

   // Simulation starts from an all-zero array
   initial begin
      for (int i = 0; i < lsu_pkg::RAM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Lane writes
   always_ff @(posedge clk) begin
      for (int lane = 0; lane < lsu_pkg::NUM_LANES; lane++) begin
         if (lane_mask[lane]) begin
            mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
         end
      end
   end

   // Read every cycle; same-address write returns the old word
   always_ff @(posedge clk) begin
      rdata <= mem[word_addr];
   end

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

   // Datapath sizing
   localparam int XLEN      = 32;
   localparam int NUM_REGS  = 32;
   localparam int REG_AW    = $clog2(NUM_REGS);      // 5 bits
   localparam int RAM_DEPTH = 256;
   localparam int RAM_AW    = $clog2(RAM_DEPTH);     // Word address, 8 bits
   localparam int NUM_LANES = XLEN / 8;              // Byte lanes per word
   localparam int BYTE_AW   = RAM_AW + $clog2(NUM_LANES); // 10 bits

   typedef logic [XLEN-1:0]      word_t;
   typedef logic [REG_AW-1:0]    reg_idx_t;
   typedef logic [BYTE_AW-1:0]   byte_addr_t;
   typedef logic [NUM_LANES-1:0] lane_mask_t;

   // Access width of a load or store
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   // One load/store request, valid for a single cycle
   typedef struct packed {
      logic         valid;
      logic         is_store;
      access_size_e size;
      byte_addr_t   addr;
      reg_idx_t     reg_idx;   // Load destination or store source
   } mem_req_t;

   // Register file write port
   typedef struct packed {
      logic     valid;
      reg_idx_t idx;
      word_t    data;
   } rf_wr_t;

endpackage

//--- logic/lsu_top.sv
`timescale 1ns/100ps

// Load/store unit: register file, data RAM and the control between them
module lsu_top (
   input  logic              clk,
   input  logic              rst,
   input  lsu_pkg::mem_req_t mem_req,
   input  lsu_pkg::rf_wr_t   ext_wr,
   input  lsu_pkg::reg_idx_t rd_idx_a,
   input  lsu_pkg::reg_idx_t rd_idx_b,
   output lsu_pkg::word_t    rd_data_a,
   output lsu_pkg::word_t    rd_data_b,
   output logic              load_done
);

   lsu_pkg::reg_idx_t          store_idx;
   lsu_pkg::rf_wr_t            rf_wr;
   lsu_pkg::word_t             port2_data;   // rd_idx_b or store source
   logic [lsu_pkg::RAM_AW-1:0] ram_addr;
   lsu_pkg::lane_mask_t        lane_mask;
   lsu_pkg::word_t             ram_wdata;
   lsu_pkg::word_t             ram_rdata;

   assign rd_data_b = port2_data;

   access_ctrl u_access_ctrl (
      .clk        (clk),
      .rst        (rst),
      .mem_req    (mem_req),
      .ext_wr     (ext_wr),
      .rd_idx_b   (rd_idx_b),
      .store_data (port2_data),
      .ram_rdata  (ram_rdata),
      .store_idx  (store_idx),
      .ram_addr   (ram_addr),
      .lane_mask  (lane_mask),
      .ram_wdata  (ram_wdata),
      .rf_wr      (rf_wr),
      .load_done  (load_done)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .rst       (rst),
      .wr        (rf_wr),
      .rd_idx_1  (rd_idx_a),
      .rd_idx_2  (store_idx),
      .rd_data_1 (rd_data_a),
      .rd_data_2 (port2_data)
   );

   data_ram u_data_ram (
      .clk       (clk),
      .word_addr (ram_addr),
      .lane_mask (lane_mask),
      .wdata     (ram_wdata),
      .rdata     (ram_rdata)
   );

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

// 32 x 32 register file, one write port and two combinational read ports.
// Register 0 is never written, so it always reads back zero after reset.
module reg_file (
   input  logic             clk,
   input  logic             rst,
   input  lsu_pkg::rf_wr_t  wr,
   input  lsu_pkg::reg_idx_t rd_idx_1,
   input  lsu_pkg::reg_idx_t rd_idx_2,
   output lsu_pkg::word_t   rd_data_1,
   output lsu_pkg::word_t   rd_data_2
);

   lsu_pkg::word_t regs [lsu_pkg::NUM_REGS];

   logic wr_en;

   assign wr_en = wr.valid && (wr.idx != '0);   // Drop writes to r0

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < lsu_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr.idx] <= wr.data;
      end
   end

   // Asynchronous reads, no write bypass
   assign rd_data_1 = regs[rd_idx_1];
   assign rd_data_2 = regs[rd_idx_2];

endmodule

//--- lsu_top.f
logic/lsu_pkg.sv
logic/reg_file.sv
logic/data_ram.sv
logic/access_ctrl.sv
logic/lsu_top.sv
verif/lsu_tb.sv

//--- verif/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;

   logic              clk;
   logic              rst;
   lsu_pkg::mem_req_t mem_req;
   lsu_pkg::rf_wr_t   ext_wr;
   lsu_pkg::reg_idx_t rd_idx_a;
   lsu_pkg::reg_idx_t rd_idx_b;
   lsu_pkg::word_t    rd_data_a;
   lsu_pkg::word_t    rd_data_b;
   logic              load_done;

   integer seed     = 32'h6867;
   int     errors   = 0;
   int     timeouts = 0;

   // Reference model with a byte-addressed memory
   lsu_pkg::word_t    regs_m [lsu_pkg::NUM_REGS];
   logic [7:0]        mem_m [lsu_pkg::RAM_DEPTH * lsu_pkg::NUM_LANES];
   logic              ld_pend;               // Load waiting for write-back
   lsu_pkg::reg_idx_t ld_dest;
   lsu_pkg::word_t    ld_val;
   lsu_pkg::word_t    exp_a;
   lsu_pkg::word_t    exp_b;
   lsu_pkg::word_t    st_data;

   lsu_top DUT (
      .clk       (clk),
      .rst       (rst),
      .mem_req   (mem_req),
      .ext_wr    (ext_wr),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .load_done (load_done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rnd(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic lsu_pkg::reg_idx_t rand_idx();
      return lsu_pkg::reg_idx_t'($random(seed));
   endfunction

   function automatic lsu_pkg::byte_addr_t rand_addr();
      return lsu_pkg::byte_addr_t'($random(seed));
   endfunction

   function automatic lsu_pkg::access_size_e rand_size();
      return lsu_pkg::access_size_e'(rnd(3));
   endfunction

   function automatic lsu_pkg::mem_req_t make_req(logic store, lsu_pkg::access_size_e size,
                                                   lsu_pkg::byte_addr_t addr,
                                                   lsu_pkg::reg_idx_t idx);
      lsu_pkg::mem_req_t r;
      r.valid    = 1'b1;
      r.is_store = store;
      r.size     = size;
      r.addr     = addr;
      r.reg_idx  = idx;
      return r;
   endfunction

   function automatic lsu_pkg::rf_wr_t make_wr(lsu_pkg::reg_idx_t idx, lsu_pkg::word_t data);
      lsu_pkg::rf_wr_t w;
      w.valid = 1'b1;
      w.idx   = idx;
      w.data  = data;
      return w;
   endfunction

   function automatic int size_bytes(lsu_pkg::access_size_e s);
      case (s)
         lsu_pkg::SIZE_BYTE: return 1;
         lsu_pkg::SIZE_HALF: return 2;
         default:            return 4;
      endcase
   endfunction

   // Naturally aligned little-endian bytes
   function automatic void store_bytes(lsu_pkg::access_size_e s, lsu_pkg::byte_addr_t addr,
                                       lsu_pkg::word_t data);
      lsu_pkg::byte_addr_t base;
      lsu_pkg::byte_addr_t a;
      int                  n;
      n    = size_bytes(s);
      base = addr & ~lsu_pkg::byte_addr_t'(n - 1);
      for (int i = 0; i < n; i++) begin
         a        = base + lsu_pkg::byte_addr_t'(i);
         mem_m[a] = 8'(data >> (8 * i));
      end
   endfunction

   function automatic lsu_pkg::word_t load_bytes(lsu_pkg::access_size_e s,
                                                 lsu_pkg::byte_addr_t addr);
      lsu_pkg::byte_addr_t base;
      lsu_pkg::byte_addr_t a;
      lsu_pkg::word_t      v;
      int                  n;
      n    = size_bytes(s);
      base = addr & ~lsu_pkg::byte_addr_t'(n - 1);
      v    = '0;                                   // Zero-extended
      for (int i = 0; i < n; i++) begin
         a = base + lsu_pkg::byte_addr_t'(i);
         v = v | (lsu_pkg::word_t'(mem_m[a]) << (8 * i));
      end
      return v;
   endfunction

   // Compare in mid-cycle, then advance the model across the next edge
   always @(negedge clk) begin
      if (rst) begin
         regs_m  = '{default: '0};
         mem_m   = '{default: '0};                 // RAM starts all zero
         ld_pend = 1'b0;
      end else begin
         exp_a = regs_m[rd_idx_a];
         if (mem_req.valid && mem_req.is_store) begin
            exp_b = regs_m[mem_req.reg_idx];       // Port 2 shows the store source
         end else begin
            exp_b = regs_m[rd_idx_b];
         end
         assert (rd_data_a === exp_a) else begin
            errors++;
            $display("mismatch at %0t: rd_data_a = %h, expected %h", $time, rd_data_a, exp_a);
         end
         assert (rd_data_b === exp_b) else begin
            errors++;
            $display("mismatch at %0t: rd_data_b = %h, expected %h", $time, rd_data_b, exp_b);
         end
         assert (load_done === ld_pend) else begin
            errors++;
            $display("mismatch at %0t: load_done = %b, expected %b", $time, load_done, ld_pend);
         end
         st_data = regs_m[mem_req.reg_idx];        // Old value before write-back
         if (ld_pend) begin
            if (ld_dest != '0) begin
               regs_m[ld_dest] = ld_val;           // External write is dropped
            end
         end else if (ext_wr.valid && ext_wr.idx != '0) begin
            regs_m[ext_wr.idx] = ext_wr.data;
         end
         ld_pend = mem_req.valid && !mem_req.is_store;
         if (mem_req.valid && mem_req.is_store) begin
            store_bytes(mem_req.size, mem_req.addr, st_data);
         end
         if (ld_pend) begin
            ld_val  = load_bytes(mem_req.size, mem_req.addr);
            ld_dest = mem_req.reg_idx;
         end
      end
   end

   task automatic drive_cycle(lsu_pkg::mem_req_t req, lsu_pkg::rf_wr_t wr,
                              lsu_pkg::reg_idx_t ia, lsu_pkg::reg_idx_t ib);
      @(posedge clk);
      mem_req  <= req;
      ext_wr   <= wr;
      rd_idx_a <= ia;
      rd_idx_b <= ib;
   endtask

   task automatic wait_load_done();
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < 8) begin
         @(posedge clk);
         mem_req <= '0;
         ext_wr  <= '0;
         @(negedge clk);
         seen = load_done;
         n++;
      end
      assert (seen) else begin
         timeouts++;
         $display("load_done never came within 8 cycles of a load, time %0t", $time);
      end
   endtask

   initial begin
      lsu_pkg::mem_req_t   req;
      lsu_pkg::rf_wr_t     wr;
      lsu_pkg::reg_idx_t   idx;
      lsu_pkg::reg_idx_t   dest;
      lsu_pkg::byte_addr_t addr;
      lsu_pkg::reg_idx_t   prev_dest;
      logic                prev_load;

      rst      <= 1'b1;
      mem_req  <= '0;
      ext_wr   <= '0;
      rd_idx_a <= '0;
      rd_idx_b <= '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Every register after reset with no requests
      for (int i = 0; i < lsu_pkg::NUM_REGS; i++) begin
         drive_cycle('0, '0, lsu_pkg::reg_idx_t'(i), lsu_pkg::reg_idx_t'(31 - i));
      end

      // External writes read back next cycle
      for (int n = 0; n < 64; n++) begin
         idx = rand_idx();
         if (n % 8 == 0) begin
            idx = '0;
         end
         drive_cycle('0, make_wr(idx, $random(seed)), rand_idx(), rand_idx());
         drive_cycle('0, '0, idx, idx);
      end

      // Word round trip
      for (int n = 0; n < 32; n++) begin
         addr      = rand_addr();
         addr[1:0] = 2'b00;
         dest      = rand_idx();
         drive_cycle(make_req(1'b1, lsu_pkg::SIZE_WORD, addr, rand_idx()), '0, dest, dest);
         drive_cycle(make_req(1'b0, lsu_pkg::SIZE_WORD, addr, dest), '0, dest, dest);
         wait_load_done();
         drive_cycle('0, '0, dest, dest);          // Loaded value on both ports
      end

      // Partial store, whole-word check, then a load at a random offset
      for (int n = 0; n < 48; n++) begin
         addr = rand_addr();
         dest = rand_idx();
         req  = make_req(1'b1, (rnd(2) == 0) ? lsu_pkg::SIZE_BYTE : lsu_pkg::SIZE_HALF,
                         addr, rand_idx());
         drive_cycle(req, '0, dest, dest);
         drive_cycle(make_req(1'b0, lsu_pkg::SIZE_WORD, addr, dest), '0, dest, dest);
         wait_load_done();
         addr[1:0] = 2'(rnd(4));
         drive_cycle(make_req(1'b0, rand_size(), addr, dest), '0, dest, dest);
         wait_load_done();
         drive_cycle('0, '0, dest, dest);          // Loaded value on both ports
      end

      // External write in the write-back cycle loses
      for (int n = 0; n < 16; n++) begin
         addr = rand_addr();
         dest = rand_idx();
         if (dest == '0) begin
            dest = 5'd1;
         end
         drive_cycle(make_req(1'b1, lsu_pkg::SIZE_WORD, addr, rand_idx()), '0, dest, dest);
         drive_cycle(make_req(1'b0, lsu_pkg::SIZE_WORD, addr, dest), '0, dest, dest);
         drive_cycle('0, make_wr(dest, $random(seed)), dest, dest);
         drive_cycle('0, '0, dest, dest);
      end

      // Mixed back-to-back traffic
      prev_load = 1'b0;
      prev_dest = '0;
      for (int n = 0; n < 2000; n++) begin
         req = '0;
         if (rnd(10) < 7) begin
            if (prev_load && rnd(4) == 0) begin
               req = make_req(1'b1, rand_size(), rand_addr(), prev_dest);   // Store of a loading reg
            end else begin
               req = make_req(rnd(2) == 1, rand_size(), rand_addr(), rand_idx());
            end
         end
         wr = '0;
         if (rnd(2) == 0) begin
            wr = make_wr(rand_idx(), $random(seed));
         end
         prev_load = req.valid && !req.is_store;
         prev_dest = req.reg_idx;
         drive_cycle(req, wr, rand_idx(), rand_idx());
      end
      repeat (3) drive_cycle('0, '0, '0, '0);

      $display("Closing counts: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
